// ==== cache_ctrl.sv ====
`default_nettype none

module cache_ctrl
  import wb_pkg::*;
  import cache_pkg::*;
#(
  parameter int ADDR_BITS  = 16,
  parameter int INDEX_BITS = 5,
  localparam int TAG_BITS  = ADDR_BITS - INDEX_BITS - 2,
  localparam int LINE_BITS = TAG_LSB + TAG_BITS,
  localparam int REQ_BITS  = ADDR_BITS + REQ_FIXED_BITS
) (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire  [REQ_BITS-1:0]   req_i,
  input  wire                   fifo_empty_i,
  input  wire                   stats_req_i,
  input  wire  [1:0]            stats_sel_i,
  input  wire  [LINE_BITS-1:0]  line0_i,
  input  wire  [LINE_BITS-1:0]  line1_i,
  input  wire                   mem_ack_i,
  input  wire  [DATA_BITS-1:0]  mem_dat_i,
  output logic                  pop_o,
  output logic                  done_o,
  output logic [DATA_BITS-1:0]  host_dat_o,
  output logic [INDEX_BITS-1:0] ram_addr_o,
  output logic                  ram_we0_o,
  output logic                  ram_we1_o,
  output logic [LINE_BITS-1:0]  line0_o,
  output logic [LINE_BITS-1:0]  line1_o,
  output logic                  mem_cyc_o,
  output logic                  mem_stb_o,
  output logic                  mem_we_o,
  output logic [ADDR_BITS-1:0]  mem_adr_o,
  output logic [DATA_BITS-1:0]  mem_dat_o
);

  ctrl_state_t           state_q;
  logic [INDEX_BITS-1:0] init_idx_q;
  logic [1:0]            beat_q;
  logic                  gap_q;
  logic                  stats_pend_q;
  logic                  hit_way_q;
  logic                  victim_q;
  logic [DATA_BITS-1:0]  stat_q [NUM_STATS];
  logic [REQ_BITS-1:0]   req_q;
  logic [LINE_BITS-1:0]  line_q [2];

  logic                  req_we;
  logic [ADDR_BITS-1:0]  req_adr;
  logic [DATA_BITS-1:0]  req_dat;
  logic [SEL_BITS-1:0]   req_sel;
  logic [TAG_BITS-1:0]   req_tag;
  logic [INDEX_BITS-1:0] req_idx;
  logic [1:0]            req_word;
  logic [1:0]            hit;
  logic [LINE_BITS-1:0]  victim_line;
  logic                  victim_dirty;
  logic                  beat_ack;
  logic [DATA_BITS-1:0]  stat_word;

  assign {req_we, req_adr, req_dat, req_sel} = req_q;
  assign req_tag  = req_adr[ADDR_BITS-1 -: TAG_BITS];
  assign req_idx  = req_adr[2 +: INDEX_BITS];
  assign req_word = req_adr[1:0];

  assign hit[0] = line0_i[VALID_BIT] & (line0_i[TAG_LSB +: TAG_BITS] == req_tag);
  assign hit[1] = line1_i[VALID_BIT] & (line1_i[TAG_LSB +: TAG_BITS] == req_tag);

  assign victim_line  = line_q[victim_q];
  assign victim_dirty = victim_line[VALID_BIT] & (|victim_line[DIRTY_LSB +: WORDS_PER_LINE]);

  always_comb
  begin
    stat_word = '0;
    if (stats_sel_i < NUM_STATS)
      stat_word = stat_q[stats_sel_i];
  end

  assign pop_o = (state_q == CS_IDLE) & ~fifo_empty_i;
  // a stats wait must not finish on the done of a late posted write
  assign done_o = (state_q == CS_DONE) & (stats_pend_q == stats_req_i);

  assign ram_addr_o = (state_q == CS_INIT) ? init_idx_q : req_idx;
  assign ram_we0_o  = (state_q == CS_INIT) | ((state_q == CS_DONE) & ~stats_pend_q) |
                      ((state_q == CS_FILL_COMMIT) & ~victim_q);
  assign ram_we1_o  = (state_q == CS_INIT) | ((state_q == CS_DONE) & ~stats_pend_q) |
                      ((state_q == CS_FILL_COMMIT) & victim_q);
  assign line0_o    = (state_q == CS_INIT) ? '0 : line_q[0];  // sweep clears valid
  assign line1_o    = (state_q == CS_INIT) ? '0 : line_q[1];

  // stb drops for one cycle after each acked beat
  assign mem_cyc_o = (state_q == CS_FLUSH) | (state_q == CS_FILL);
  assign mem_stb_o = mem_cyc_o & ~gap_q;
  assign mem_we_o  = (state_q == CS_FLUSH);
  assign mem_adr_o = {mem_we_o ? victim_line[TAG_LSB +: TAG_BITS] : req_tag, req_idx, beat_q};
  assign mem_dat_o = victim_line[beat_q*DATA_BITS +: DATA_BITS];
  assign beat_ack  = mem_stb_o & mem_ack_i;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q      <= CS_INIT;
      init_idx_q   <= '0;
      beat_q       <= '0;
      gap_q        <= 1'b0;
      stats_pend_q <= 1'b0;
      hit_way_q    <= 1'b0;
      victim_q     <= 1'b0;
      host_dat_o   <= '0;
      for (int i = 0; i < NUM_STATS; i++)
        stat_q[i] <= '0;
    end
    else
    begin
      gap_q <= beat_ack;
      case (state_q)
        CS_INIT:
        begin
          init_idx_q <= init_idx_q + 1'b1;
          if (&init_idx_q)
            state_q <= CS_IDLE;
        end
        CS_IDLE:
        begin
          if (!fifo_empty_i)
            state_q <= CS_LOOKUP;
          else if (stats_req_i)  // queue drained first
          begin
            host_dat_o   <= stat_word;
            stats_pend_q <= 1'b1;
            state_q      <= CS_DONE;
          end
        end
        CS_LOOKUP:
          state_q <= CS_COMPARE;  // ram read in flight
        CS_COMPARE:
        begin
          hit_way_q <= hit[1];
          victim_q  <= line1_i[LRU_BIT];  // way 1 marked lru
          state_q   <= (|hit) ? CS_HIT : CS_MISS;
        end
        CS_HIT:
        begin
          if (!req_we)
            host_dat_o <= line_q[hit_way_q][req_word*DATA_BITS +: DATA_BITS];
          stat_q[STAT_HITS] <= stat_q[STAT_HITS] + 1'b1;
          state_q <= CS_DONE;
        end
        CS_MISS:
        begin
          beat_q  <= '0;
          state_q <= victim_dirty ? CS_FLUSH : CS_FILL;
        end
        CS_FLUSH:
        begin
          if (beat_ack)
          begin
            beat_q <= beat_q + 1'b1;  // wraps to 0 for the fill
            if (beat_q == 2'd3)
              state_q <= CS_FLUSH_DONE;
          end
        end
        CS_FLUSH_DONE:
        begin
          stat_q[STAT_FLUSHES] <= stat_q[STAT_FLUSHES] + 1'b1;
          state_q <= CS_FILL;
        end
        CS_FILL:
        begin
          if (beat_ack)
          begin
            beat_q <= beat_q + 1'b1;
            if (beat_q == 2'd3)
              state_q <= CS_FILL_COMMIT;
          end
        end
        CS_FILL_COMMIT:
        begin
          stat_q[STAT_FILLS] <= stat_q[STAT_FILLS] + 1'b1;
          state_q <= CS_LOOKUP;  // replay as a hit
        end
        CS_DONE:
        begin
          stats_pend_q <= 1'b0;
          state_q      <= CS_IDLE;
        end
        default:
          state_q <= CS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pop_o)
      req_q <= req_i;
    case (state_q)
      CS_COMPARE:
      begin
        line_q[0] <= line0_i;
        line_q[1] <= line1_i;
      end
      CS_HIT:
      begin
        line_q[hit_way_q][LRU_BIT]  <= 1'b0;
        line_q[~hit_way_q][LRU_BIT] <= 1'b1;
        if (req_we)
        begin
          line_q[hit_way_q][DIRTY_LSB + req_word] <= 1'b1;
          for (int b = 0; b < SEL_BITS; b++)
            if (req_sel[b])
              line_q[hit_way_q][req_word*DATA_BITS + 8*b +: 8] <= req_dat[8*b +: 8];
        end
      end
      CS_FILL:
      begin
        if (beat_ack)
        begin
          line_q[victim_q][beat_q*DATA_BITS +: DATA_BITS] <= mem_dat_i;
          if (beat_q == 2'd3)  // last beat completes the line
          begin
            line_q[victim_q][VALID_BIT]                    <= 1'b1;
            line_q[victim_q][DIRTY_LSB +: WORDS_PER_LINE]  <= '0;
            line_q[victim_q][TAG_LSB +: TAG_BITS]          <= req_tag;
          end
        end
      end
      default:
      begin
      end
    endcase
  end

  // a beat keeps its address until the slave acks it
  a_beat_held:   assert property (@(posedge clk_i) disable iff (rst_i)
                                  mem_stb_o && !mem_ack_i |=> mem_stb_o && $stable(mem_adr_o));
  a_flush_dirty: assert property (@(posedge clk_i) disable iff (rst_i)
                                  mem_we_o |-> victim_dirty);

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  import wb_pkg::*;

  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_DATA_BITS = WORDS_PER_LINE * DATA_BITS;

  // words at the bottom of a line and the tag on top
  localparam int LRU_BIT   = LINE_DATA_BITS;
  localparam int VALID_BIT = LRU_BIT + 1;
  localparam int DIRTY_LSB = VALID_BIT + 1;            // one per word
  localparam int TAG_LSB   = DIRTY_LSB + WORDS_PER_LINE;

  localparam int STAT_HITS    = 0;
  localparam int STAT_FLUSHES = 1;
  localparam int STAT_FILLS   = 2;
  localparam int NUM_STATS    = 3;

  typedef enum logic [3:0]
  {
    CS_INIT,
    CS_IDLE,
    CS_LOOKUP,
    CS_COMPARE,
    CS_HIT,
    CS_MISS,
    CS_FILL,          // four read beats
    CS_FILL_COMMIT,
    CS_FLUSH,         // four write beats
    CS_FLUSH_DONE,
    CS_DONE
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== cache_top.f ====
wb_pkg.sv
cache_pkg.sv
req_fifo.sv
cache_way_ram.sv
host_port.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
tb_cache_top.sv

// ==== cache_top.sv ====
`default_nettype none

module cache_top
  import wb_pkg::*;
  import cache_pkg::*;
#(
  parameter int ADDR_BITS       = 16,
  parameter int INDEX_BITS      = 5,
  parameter int FIFO_DEPTH_BITS = 2
) (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wire                  cyc_i,
  input  wire                  stb_i,
  input  wire                  we_i,
  input  wire  [ADDR_BITS-1:0] adr_i,
  input  wire  [DATA_BITS-1:0] dat_i,
  input  wire  [SEL_BITS-1:0]  sel_i,
  input  wire                  stats_stb_i,
  output logic                 ack_o,
  output logic [DATA_BITS-1:0] dat_o,
  output logic                 mem_cyc_o,
  output logic                 mem_stb_o,
  output logic                 mem_we_o,
  output logic [ADDR_BITS-1:0] mem_adr_o,
  output logic [DATA_BITS-1:0] mem_dat_o,
  input  wire                  mem_ack_i,
  input  wire  [DATA_BITS-1:0] mem_dat_i
);

  localparam int TAG_BITS  = ADDR_BITS - INDEX_BITS - 2;
  localparam int LINE_BITS = TAG_LSB + TAG_BITS;
  localparam int REQ_BITS  = ADDR_BITS + REQ_FIXED_BITS;

  logic                  push, pop, fifo_full, fifo_empty, ctrl_done;
  logic [REQ_BITS-1:0]   head;
  logic [INDEX_BITS-1:0] ram_addr;
  logic                  ram_we0, ram_we1;
  logic [LINE_BITS-1:0]  wr_line0, wr_line1, rd_line0, rd_line1;

  host_port u_host (
    .clk_i(clk_i), .rst_i(rst_i),
    .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .stats_stb_i(stats_stb_i),
    .fifo_full_i(fifo_full), .fifo_empty_i(fifo_empty), .ctrl_done_i(ctrl_done),
    .push_o(push), .ack_o(ack_o)
  );

  req_fifo #(.REQ_BITS(REQ_BITS), .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) u_fifo (
    .clk_i(clk_i), .rst_i(rst_i),
    .push_i(push), .pop_i(pop),
    .data_i({we_i, adr_i, dat_i, sel_i}),
    .data_o(head), .full_o(fifo_full), .empty_o(fifo_empty)
  );

  cache_ctrl #(.ADDR_BITS(ADDR_BITS), .INDEX_BITS(INDEX_BITS)) u_ctrl (
    .clk_i(clk_i), .rst_i(rst_i),
    .req_i(head), .fifo_empty_i(fifo_empty),
    .stats_req_i(cyc_i & stb_i & stats_stb_i), .stats_sel_i(adr_i[1:0]),
    .line0_i(rd_line0), .line1_i(rd_line1),
    .mem_ack_i(mem_ack_i), .mem_dat_i(mem_dat_i),
    .pop_o(pop), .done_o(ctrl_done), .host_dat_o(dat_o),
    .ram_addr_o(ram_addr), .ram_we0_o(ram_we0), .ram_we1_o(ram_we1),
    .line0_o(wr_line0), .line1_o(wr_line1),
    .mem_cyc_o(mem_cyc_o), .mem_stb_o(mem_stb_o), .mem_we_o(mem_we_o),
    .mem_adr_o(mem_adr_o), .mem_dat_o(mem_dat_o)
  );

  cache_way_ram #(.ADDR_BITS(ADDR_BITS), .INDEX_BITS(INDEX_BITS)) u_way0 (
    .clk_i(clk_i), .addr_i(ram_addr), .we_i(ram_we0),
    .line_i(wr_line0), .line_o(rd_line0)
  );

  cache_way_ram #(.ADDR_BITS(ADDR_BITS), .INDEX_BITS(INDEX_BITS)) u_way1 (
    .clk_i(clk_i), .addr_i(ram_addr), .we_i(ram_we1),
    .line_i(wr_line1), .line_o(rd_line1)
  );

endmodule

`default_nettype wire

// ==== cache_way_ram.sv ====
`default_nettype none

module cache_way_ram
  import cache_pkg::*;
#(
  parameter int ADDR_BITS  = 16,
  parameter int INDEX_BITS = 5,
  localparam int TAG_BITS  = ADDR_BITS - INDEX_BITS - 2,
  localparam int LINE_BITS = TAG_LSB + TAG_BITS
) (
  input  wire                   clk_i,
  input  wire  [INDEX_BITS-1:0] addr_i,
  input  wire                   we_i,
  input  wire  [LINE_BITS-1:0]  line_i,
  output logic [LINE_BITS-1:0]  line_o
);

  // lru, valid, dirty, tag and words of one way per set
  logic [LINE_BITS-1:0] mem_q [2**INDEX_BITS];

  always_ff @(posedge clk_i)
  begin
    if (we_i)
      mem_q[addr_i] <= line_i;
    line_o <= mem_q[addr_i];  // old data on a same-cycle write
  end

endmodule

`default_nettype wire

// ==== host_port.sv ====
`default_nettype none

module host_port
  import wb_pkg::*;
(
  input  wire  clk_i,
  input  wire  rst_i,
  input  wire  cyc_i,
  input  wire  stb_i,
  input  wire  we_i,
  input  wire  stats_stb_i,
  input  wire  fifo_full_i,
  input  wire  fifo_empty_i,
  input  wire  ctrl_done_i,
  output logic push_o,
  output logic ack_o
);

  host_state_t state_q;
  host_state_t state_d;
  logic        accept;

  // stats requests bypass the queue, so a full queue does not block them
  assign accept = (state_q == HS_IDLE) & cyc_i & stb_i & (~fifo_full_i | stats_stb_i);
  assign push_o = accept & ~stats_stb_i;
  assign ack_o  = (state_q == HS_DONE);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      HS_IDLE:
      begin
        if (accept)
          state_d = (we_i & ~stats_stb_i) ? HS_DONE : HS_READ_WAIT;  // posted write
      end
      HS_READ_WAIT:
      begin
        if (fifo_empty_i & ctrl_done_i)
          state_d = HS_DONE;
      end
      HS_DONE:
        state_d = HS_IDLE;
      default:
        state_d = HS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      state_q <= HS_IDLE;
    else
      state_q <= state_d;
  end

  // host holds its request while a read is pending
  a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
                               (state_q == HS_READ_WAIT) |-> (cyc_i & stb_i));

endmodule

`default_nettype wire

// ==== req_fifo.sv ====
`default_nettype none

module req_fifo #(
  parameter int REQ_BITS        = 53,
  parameter int FIFO_DEPTH_BITS = 2
) (
  input  wire                 clk_i,
  input  wire                 rst_i,
  input  wire                 push_i,
  input  wire                 pop_i,
  input  wire  [REQ_BITS-1:0] data_i,
  output logic [REQ_BITS-1:0] data_o,
  output logic                full_o,
  output logic                empty_o
);

  localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;

  logic [REQ_BITS-1:0]        mem_q [DEPTH];
  logic [FIFO_DEPTH_BITS-1:0] wr_ptr_q;
  logic [FIFO_DEPTH_BITS-1:0] rd_ptr_q;
  logic [FIFO_DEPTH_BITS:0]   count_q;

  assign data_o  = mem_q[rd_ptr_q];  // head shown without a read cycle
  assign full_o  = count_q[FIFO_DEPTH_BITS];
  assign empty_o = (count_q == '0);

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== tb_cache_top.sv ====
`default_nettype none

module tb_cache_top
  import wb_pkg::*;
  import cache_pkg::*;
();

  localparam int ADDR_BITS  = 16;
  localparam int INDEX_BITS = 5;
  localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS - 2;
  localparam int SETS       = 2 ** INDEX_BITS;
  localparam int TIMEOUT    = 2000;  // cycles per bus wait

  logic                 clk;
  logic                 rst;
  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [ADDR_BITS-1:0] adr;
  logic [DATA_BITS-1:0] wdat;
  logic [SEL_BITS-1:0]  sel;
  logic                 stats_stb;
  logic                 ack;
  logic [DATA_BITS-1:0] rdat;
  logic                 mem_cyc;
  logic                 mem_stb;
  logic                 mem_we;
  logic [ADDR_BITS-1:0] mem_adr;
  logic [DATA_BITS-1:0] mem_wdat;
  logic                 mem_ack;
  logic [DATA_BITS-1:0] mem_rdat;

  // host view of memory plus a tag model of the cache
  logic [DATA_BITS-1:0]      shadow [2**ADDR_BITS];
  logic                      way_valid [2*SETS];
  logic [TAG_BITS-1:0]       way_tag [2*SETS];
  logic [WORDS_PER_LINE-1:0] way_dirty [2*SETS];
  logic                      lru_way1 [SETS];
  logic [ADDR_BITS-1:0]      burst_addr [8];

  int     hit_count;
  int     flush_count;
  int     fill_count;
  int     checks;
  int     errors;
  int     tests;
  int     failed_tests;
  integer seed = 44483;

  cache_top #(.ADDR_BITS(ADDR_BITS), .INDEX_BITS(INDEX_BITS), .FIFO_DEPTH_BITS(2)) u_dut (
    .clk_i(clk), .rst_i(rst),
    .cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr), .dat_i(wdat), .sel_i(sel),
    .stats_stb_i(stats_stb), .ack_o(ack), .dat_o(rdat),
    .mem_cyc_o(mem_cyc), .mem_stb_o(mem_stb), .mem_we_o(mem_we),
    .mem_adr_o(mem_adr), .mem_dat_o(mem_wdat),
    .mem_ack_i(mem_ack), .mem_dat_i(mem_rdat)
  );

  tb_mem_model #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) u_mem (
    .clk_i(clk), .rst_i(rst),
    .cyc_i(mem_cyc), .stb_i(mem_stb), .we_i(mem_we), .adr_i(mem_adr), .dat_i(mem_wdat),
    .ack_o(mem_ack), .dat_o(mem_rdat)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [DATA_BITS-1:0] preload_value(input logic [ADDR_BITS-1:0] a);
    return {a ^ 16'h5a5a, a};
  endfunction

  function automatic logic [DATA_BITS-1:0] merge_bytes(input logic [DATA_BITS-1:0] old,
                                                       input logic [DATA_BITS-1:0] d,
                                                       input logic [SEL_BITS-1:0]  s);
    logic [DATA_BITS-1:0] r;
    r = old;
    for (int b = 0; b < SEL_BITS; b++)
      if (s[b])
        r[8*b +: 8] = d[8*b +: 8];
    return r;
  endfunction

  // a few tags per set so that lines get evicted
  task automatic random_addr(output logic [ADDR_BITS-1:0] a);
    logic [31:0] r;
    r = $random(seed);
    a = '0;
    a[ADDR_BITS-1 -: TAG_BITS] = TAG_BITS'(r[9:8]);
    a[2 +: INDEX_BITS]         = r[6:2];
    a[1:0]                     = r[1:0];
  endtask

  task automatic model_access(input logic [ADDR_BITS-1:0] a, input logic is_write);
    int                  set;
    int                  way;
    logic [TAG_BITS-1:0] tag;
    set = a[2 +: INDEX_BITS];
    tag = a[ADDR_BITS-1 -: TAG_BITS];
    way = -1;
    for (int w = 0; w < 2; w++)
      if (way_valid[2*set+w] && way_tag[2*set+w] == tag)
        way = w;
    if (way < 0)
    begin
      way = lru_way1[set] ? 1 : 0;
      if (way_valid[2*set+way] && (|way_dirty[2*set+way]))
        flush_count++;
      fill_count++;
      way_valid[2*set+way] = 1'b1;
      way_tag[2*set+way]   = tag;
      way_dirty[2*set+way] = '0;
    end
    hit_count++;  // a miss is replayed as a hit
    if (is_write)
      way_dirty[2*set+way][a[1:0]] = 1'b1;
    lru_way1[set] = (way == 0);
  endtask

  // starts 10 units after an edge and ends one idle cycle after ack
  task automatic bus_access(input  logic                 is_write,
                            input  logic                 is_stats,
                            input  logic [ADDR_BITS-1:0] a,
                            input  logic [DATA_BITS-1:0] d,
                            input  logic [SEL_BITS-1:0]  s,
                            input  string                op,
                            output logic [DATA_BITS-1:0] got,
                            output int                   cycles);
    logic got_ack;
    cyc       = 1'b1;
    stb       = 1'b1;
    we        = is_write;
    stats_stb = is_stats;
    adr       = a;
    wdat      = d;
    sel       = s;
    cycles    = 0;
    got_ack   = 1'b0;
    got       = '0;
    while (!got_ack && cycles < TIMEOUT)
    begin
      @(posedge clk);
      #10;
      cycles++;
      got_ack = ack;
    end
    if (!got_ack)
    begin
      $display("timeout: %s at address %h was never acknowledged", op, a);
      $display("Regression failed");
      $finish;
    end
    else
    begin
      got       = rdat;
      cyc       = 1'b0;
      stb       = 1'b0;
      we        = 1'b0;
      stats_stb = 1'b0;
      @(posedge clk);
      #10;
    end
  endtask

  task automatic write_word(input logic [ADDR_BITS-1:0] a, input logic [DATA_BITS-1:0] d,
                            input logic [SEL_BITS-1:0] s, input logic check_latency);
    logic [DATA_BITS-1:0] unused;
    int                   cycles;
    model_access(a, 1'b1);
    shadow[a] = merge_bytes(shadow[a], d, s);
    bus_access(1'b1, 1'b0, a, d, s, "write", unused, cycles);
    if (check_latency)
    begin
      checks++;
      if (cycles != 1)
      begin
        errors++;
        $display("[FAIL] %0t write %h acked after %0d cycles, expected 1", $time, a, cycles);
      end
    end
  endtask

  task automatic read_check(input logic [ADDR_BITS-1:0] a);
    logic [DATA_BITS-1:0] got;
    int                   cycles;
    model_access(a, 1'b0);
    bus_access(1'b0, 1'b0, a, '0, 4'hf, "read", got, cycles);
    checks++;
    if (got !== shadow[a])
    begin
      errors++;
      $display("[FAIL] %0t read %h returned %h, expected %h", $time, a, got, shadow[a]);
    end
  endtask

  task automatic stats_check(input logic [1:0] which, input int expected, input string what);
    logic [DATA_BITS-1:0] got;
    int                   cycles;
    bus_access(1'b0, 1'b1, {{(ADDR_BITS-2){1'b0}}, which}, '0, '0, "stats read", got, cycles);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("[FAIL] %0t %s counter is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before)
      $display("test %s: ok", name);
    else
    begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  initial
  begin
    int                   mark;
    logic [ADDR_BITS-1:0] a;
    logic [DATA_BITS-1:0] d;
    logic [DATA_BITS-1:0] got;
    logic [31:0]          r;

    rst       = 1'b1;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    stats_stb = 1'b0;
    adr       = '0;
    wdat      = '0;
    sel       = '0;
    hit_count    = 0;
    flush_count  = 0;
    fill_count   = 0;
    checks       = 0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    for (int i = 0; i < 2**ADDR_BITS; i++)
      shadow[i] = preload_value(i[ADDR_BITS-1:0]);
    for (int i = 0; i < 2*SETS; i++)
    begin
      way_valid[i] = 1'b0;
      way_tag[i]   = '0;
      way_dirty[i] = '0;
    end
    for (int i = 0; i < SETS; i++)
      lru_way1[i] = 1'b0;

    repeat (8) @(posedge clk);
    #10;
    rst = 1'b0;

    mark = errors;
    checks++;
    if ({ack, mem_cyc, mem_stb, mem_we} !== 4'b0000)
    begin
      errors++;
      $display("[FAIL] %0t bus outputs %b not idle after reset, expected 0000",
               $time, {ack, mem_cyc, mem_stb, mem_we});
    end
    // first read lands while the init sweep is still running
    for (int i = 0; i < 8; i++)
    begin
      random_addr(a);
      read_check(a);
    end
    end_test("reads after reset", mark);

    mark = errors;
    random_addr(a);
    read_check(a);  // queue drained
    for (int i = 0; i < 8; i++)
    begin
      random_addr(burst_addr[i]);
      d = $random(seed);
      write_word(burst_addr[i], d, 4'hf, i < 4);
    end
    for (int i = 0; i < 8; i++)
      read_check(burst_addr[i]);
    end_test("posted writes", mark);

    mark = errors;
    for (int n = 0; n < 400; n++)
    begin
      random_addr(a);
      r = $random(seed);
      d = $random(seed);
      if (r[0])
        write_word(a, d, r[7:4], 1'b0);
      else
        read_check(a);
    end
    end_test("random traffic", mark);

    // tags outside the random pool, same set
    mark = errors;
    for (int t = 0; t < 3; t++)
    begin
      a = '0;
      a[ADDR_BITS-1 -: TAG_BITS] = TAG_BITS'(100 + t);
      a[2 +: INDEX_BITS]         = INDEX_BITS'(5);
      d = $random(seed);
      write_word(a, d, 4'hf, 1'b0);
    end
    read_check(a);  // waits out the flush and fill
    for (int w = 0; w < WORDS_PER_LINE; w++)
    begin
      a = '0;
      a[ADDR_BITS-1 -: TAG_BITS] = TAG_BITS'(100);
      a[2 +: INDEX_BITS]         = INDEX_BITS'(5);
      a[1:0]                     = 2'(w);
      u_mem.backdoor_read(a, got);
      checks++;
      if (got !== shadow[a])
      begin
        errors++;
        $display("[FAIL] %0t memory %h holds %h after eviction, expected %h",
                 $time, a, got, shadow[a]);
      end
    end
    end_test("eviction write-back", mark);

    mark = errors;
    stats_check(2'(STAT_HITS), hit_count, "hit");
    stats_check(2'(STAT_FLUSHES), flush_count, "flush");
    stats_check(2'(STAT_FILLS), fill_count, "fill");
    stats_check(2'd3, 0, "unused");
    end_test("statistics", mark);

    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests, failed_tests, checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`default_nettype none

module tb_mem_model #(
  parameter int ADDR_BITS = 16,
  parameter int DATA_BITS = 32,
  parameter int SEED      = 44483
) (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wire                  cyc_i,
  input  wire                  stb_i,
  input  wire                  we_i,
  input  wire  [ADDR_BITS-1:0] adr_i,
  input  wire  [DATA_BITS-1:0] dat_i,
  output logic                 ack_o,
  output logic [DATA_BITS-1:0] dat_o
);

  logic [DATA_BITS-1:0] mem_q [2**ADDR_BITS];
  logic [1:0]           delay_q;
  logic                 armed_q;
  logic [1:0]           wait_left;
  logic [31:0]          rand_word;
  integer               seed;

  initial
  begin
    seed = SEED;
    for (int i = 0; i < 2**ADDR_BITS; i++)
      mem_q[i] = {i[15:0] ^ 16'h5a5a, i[15:0]};  // every word differs
  end

  assign dat_o = ack_o ? mem_q[adr_i] : '0;

  always @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ack_o   <= 1'b0;
      armed_q <= 1'b0;
      delay_q <= '0;
    end
    else if (ack_o)
    begin
      ack_o <= 1'b0;  // beat ends here
      if (cyc_i && stb_i && we_i)
        mem_q[adr_i] <= dat_i;
    end
    else if (cyc_i && stb_i)
    begin
      if (armed_q)
        wait_left = delay_q;
      else
      begin
        rand_word = $random(seed);
        wait_left = rand_word[1:0];  // 0 to 3 extra cycles
      end
      if (wait_left == 2'd0)
      begin
        ack_o   <= 1'b1;
        armed_q <= 1'b0;
      end
      else
      begin
        delay_q <= wait_left - 1'b1;
        armed_q <= 1'b1;
      end
    end
  end

  task automatic backdoor_read(input logic [ADDR_BITS-1:0] a, output logic [DATA_BITS-1:0] d);
    d = mem_q[a];
  endtask

endmodule

`default_nettype wire

// ==== wb_pkg.sv ====
`default_nettype none

package wb_pkg;

  localparam int DATA_BITS = 32;
  localparam int SEL_BITS  = DATA_BITS / 8;

  // request record is {we, adr, dat, sel}
  // the user adds its own address width to this
  localparam int REQ_FIXED_BITS = 1 + DATA_BITS + SEL_BITS;

  typedef enum logic [1:0]
  {
    HS_IDLE,
    HS_READ_WAIT,  // read or stats blocked until drained
    HS_DONE
  } host_state_t;

endpackage

`default_nettype wire
